//--- common/addsub_pkg.sv
// Widths, operation codes, credit constants and prefix tree sizes for the add/subtract unit
`default_nettype none

package addsub_pkg;

	// Operand and result width
	localparam int data_width = 20;

	typedef logic [data_width-1:0] operand_t;

	// Operation codes carried through the queue
	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MAX,
		OP_MIN
	} op_t;

	// Queue entries, also the upstream credits after reset
	localparam int queue_depth = 4;

	// Read and write pointer width of the queue
	localparam int ptr_width = $clog2(queue_depth);

	// Downstream credits after reset
	localparam int out_credits = 4;

	// Counts 0 to 4 for both credit counters
	typedef logic [2:0] credit_cnt_t;

	// Bit pairs at the first level of the Ling tree
	localparam int ling_pairs = data_width / 2;

	// Doubling levels until every odd position reaches bit 0
	localparam int ling_levels = $clog2(data_width);

endpackage

`default_nettype wire

//--- ling_adder/ling_prefix_tree.sv
// Reduced-cell Ling prefix tree with pseudo-carries, carries and sum post-computation
`timescale 1ns/1ps
`default_nettype none

module ling_prefix_tree (
	input  wire [addsub_pkg::data_width:0] p,
	input  wire [addsub_pkg::data_width:0] g,
	output addsub_pkg::operand_t           sum,
	output logic                           cout
);

	// Reduced grey cell, lowest pair only
	function automatic logic rgry(input logic g_hi, input logic g_lo);
		return g_hi | g_lo;
	endfunction

	// Reduced black cell, returns {h, i}
	function automatic logic [1:0] rblk(input logic [1:0] gin, input logic [1:0] pin);
		return {gin[1] | gin[0], pin[1] & pin[0]};
	endfunction

	// Black cell, returns {h, i}
	function automatic logic [1:0] black(input logic [1:0] hin, input logic [1:0] iin);
		return {hin[1] | (iin[1] & hin[0]), iin[1] & iin[0]};
	endfunction

	// Grey cell, group ends at bit 0
	function automatic logic grey(input logic [1:0] hin, input logic iin);
		return hin[1] | (iin & hin[0]);
	endfunction

	// Entry k of each level belongs to odd bit position 2k+1
	wire [addsub_pkg::ling_pairs-1:0] h_lvl [1:addsub_pkg::ling_levels];
	wire [addsub_pkg::ling_pairs-1:0] i_lvl [1:addsub_pkg::ling_levels];

	// Final pseudo-carries and true carries
	wire [addsub_pkg::data_width:1] h;
	wire [addsub_pkg::data_width:1] c;

	genvar k;
	genvar lv;

	generate
		// Span-1 pairs
		for (k = 0; k < addsub_pkg::ling_pairs; k++) begin : g_lvl1
			if (k == 0) begin : g_rgry
				assign h_lvl[1][k] = rgry(g[1], g[0]);
				assign i_lvl[1][k] = 1'b0;
			end else begin : g_rblk
				assign {h_lvl[1][k], i_lvl[1][k]} =
					rblk({g[2*k+1], g[2*k]}, {p[2*k], p[2*k-1]});
			end
		end

		// Doubling spans up to 16
		for (lv = 2; lv <= addsub_pkg::ling_levels; lv++) begin : g_lvl
			for (k = 0; k < addsub_pkg::ling_pairs; k++) begin : g_pos
				if (k < (1 << (lv - 2))) begin : g_pass
					// Already reaches bit 0
					assign h_lvl[lv][k] = h_lvl[lv-1][k];
					assign i_lvl[lv][k] = i_lvl[lv-1][k];
				end else if (k < (2 << (lv - 2))) begin : g_grey
					assign h_lvl[lv][k] = grey(
						{h_lvl[lv-1][k], h_lvl[lv-1][k-(1 << (lv - 2))]},
						i_lvl[lv-1][k]);
					assign i_lvl[lv][k] = 1'b0;
				end else begin : g_black
					assign {h_lvl[lv][k], i_lvl[lv][k]} = black(
						{h_lvl[lv-1][k], h_lvl[lv-1][k-(1 << (lv - 2))]},
						{i_lvl[lv-1][k], i_lvl[lv-1][k-(1 << (lv - 2))]});
				end
			end
		end

		// Odd positions straight from the last level
		for (k = 0; k < addsub_pkg::ling_pairs; k++) begin : g_odd
			assign h[2*k+1] = h_lvl[addsub_pkg::ling_levels][k];
		end

		// Extra grey stage fills in the even positions
		for (k = 1; k < addsub_pkg::ling_pairs; k++) begin : g_even
			assign h[2*k] = grey({g[2*k], h_lvl[addsub_pkg::ling_levels][k-1]}, p[2*k-1]);
		end

		// True carry is propagate AND pseudo-carry
		for (k = 1; k < addsub_pkg::data_width; k++) begin : g_carry
			assign c[k+1] = p[k] & h[k];
		end
	endgenerate

	// Carry into bit 0 is the carry-in itself
	assign c[1] = g[0];

	// Top pseudo-carry for the carry-out
	assign h[addsub_pkg::data_width] = g[addsub_pkg::data_width] | c[addsub_pkg::data_width];

	// Ling post-computation
	assign sum = (p[addsub_pkg::data_width:1] ^ h) | (g[addsub_pkg::data_width:1] & c);
	assign cout = p[addsub_pkg::data_width] & h[addsub_pkg::data_width];

endmodule

`default_nettype wire

//--- ling_adder/ling_adder.sv
// Ling adder with optional b inversion, carry-in and registered result stage
`timescale 1ns/1ps
`default_nettype none

module ling_adder #(
	parameter bit subtract = 1'b0
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       in_valid,
	input  wire addsub_pkg::operand_t a,
	input  wire addsub_pkg::operand_t b,
	output logic                      sum_valid,
	output addsub_pkg::operand_t      sum,
	output logic                      cout
);

	addsub_pkg::operand_t b_eff;
	logic [addsub_pkg::data_width:0] p;
	logic [addsub_pkg::data_width:0] g;
	addsub_pkg::operand_t tree_sum;
	logic tree_cout;

	// a + ~b + 1 when subtracting
	assign b_eff = subtract ? ~b : b;

	// Pre-computation, carry-in sits in the lowest generate bit
	assign p = {a | b_eff, 1'b1};
	assign g = {a & b_eff, subtract};

	ling_prefix_tree u_tree (
		.p    (p),
		.g    (g),
		.sum  (tree_sum),
		.cout (tree_cout)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= in_valid;
		end
	end

	// Result captured only for issued operations
	always_ff @(posedge clk) begin
		if (in_valid) begin
			sum <= tree_sum;
			cout <= tree_cout;
		end
	end

	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(sum_valid));

endmodule

`default_nettype wire

//--- design/operand_queue.sv
// Credit-controlled operand FIFO with upstream credit return and downstream issue
`timescale 1ns/1ps
`default_nettype none

module operand_queue (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       in_valid,
	input  wire addsub_pkg::op_t      in_op,
	input  wire addsub_pkg::operand_t in_a,
	input  wire addsub_pkg::operand_t in_b,
	output logic                      in_credit,
	input  wire                       issue_ok,
	output logic                      iss_valid,
	output addsub_pkg::op_t           iss_op,
	output addsub_pkg::operand_t      iss_a,
	output addsub_pkg::operand_t      iss_b
);

	addsub_pkg::op_t op_mem [addsub_pkg::queue_depth];
	addsub_pkg::operand_t a_mem [addsub_pkg::queue_depth];
	addsub_pkg::operand_t b_mem [addsub_pkg::queue_depth];

	logic [addsub_pkg::ptr_width-1:0] wr_ptr;
	logic [addsub_pkg::ptr_width-1:0] rd_ptr;
	addsub_pkg::credit_cnt_t count;
	logic issue;

	// Head leaves when present and downstream has room
	assign issue = (count != '0) && issue_ok;

	assign iss_valid = issue;
	assign iss_op = op_mem[rd_ptr];
	assign iss_a = a_mem[rd_ptr];
	assign iss_b = b_mem[rd_ptr];

	// Freed slot goes back to upstream at once
	assign in_credit = issue;

	always_ff @(posedge clk) begin
		if (in_valid) begin
			op_mem[wr_ptr] <= in_op;
			a_mem[wr_ptr] <= in_a;
			b_mem[wr_ptr] <= in_b;
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({in_valid, issue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sending into a full queue means upstream overdrew its credits
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (count != addsub_pkg::queue_depth));

endmodule

`default_nettype wire

//--- design/result_combiner.sv
// Result selection, carry and zero flags, output register and downstream credit counter
`timescale 1ns/1ps
`default_nettype none

module result_combiner (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       iss_valid,
	input  wire addsub_pkg::op_t      iss_op,
	input  wire addsub_pkg::operand_t iss_a,
	input  wire addsub_pkg::operand_t iss_b,
	input  wire                       add_valid,
	input  wire addsub_pkg::operand_t add_sum,
	input  wire                       add_cout,
	input  wire                       sub_valid,
	input  wire addsub_pkg::operand_t sub_sum,
	input  wire                       sub_cout,
	input  wire                       out_credit,
	output logic                      issue_ok,
	output logic                      out_valid,
	output addsub_pkg::operand_t      out_result,
	output logic                      out_carry,
	output logic                      out_zero
);

	addsub_pkg::op_t op_q;
	addsub_pkg::operand_t a_q;
	addsub_pkg::operand_t b_q;
	addsub_pkg::credit_cnt_t credit_cnt;
	addsub_pkg::operand_t result;
	logic carry;

	assign issue_ok = (credit_cnt != '0);

	// Travels alongside the adder stage
	always_ff @(posedge clk) begin
		if (iss_valid) begin
			op_q <= iss_op;
			a_q <= iss_a;
			b_q <= iss_b;
		end
	end

	// sub_cout set means a >= b
	always_comb begin
		result = add_sum;
		carry = add_cout;
		case (op_q)
			addsub_pkg::OP_ADD: begin
				result = add_sum;
				carry = add_cout;
			end
			addsub_pkg::OP_SUB: begin
				result = sub_sum;
				carry = sub_cout;
			end
			addsub_pkg::OP_MAX: begin
				result = sub_cout ? a_q : b_q;
				carry = sub_cout;
			end
			addsub_pkg::OP_MIN: begin
				result = sub_cout ? b_q : a_q;
				carry = sub_cout;
			end
			default: begin
				result = add_sum;
				carry = add_cout;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= add_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (add_valid) begin
			out_result <= result;
			out_carry <= carry;
			out_zero <= (result == '0);
		end
	end

	// One credit per issue, one back per out_credit pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credit_cnt <= addsub_pkg::credit_cnt_t'(addsub_pkg::out_credits);
		end else begin
			case ({iss_valid, out_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	a_adders_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		add_valid == sub_valid);

	// Downstream returned more than it was granted
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credit_cnt <= addsub_pkg::out_credits);

endmodule

`default_nettype wire

//--- design/addsub_unit.sv
// Top level of the add/subtract/compare unit with queue, two Ling adders and combiner
`timescale 1ns/1ps
`default_nettype none

module addsub_unit (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       in_valid,
	input  wire addsub_pkg::op_t      in_op,
	input  wire addsub_pkg::operand_t in_a,
	input  wire addsub_pkg::operand_t in_b,
	output logic                      in_credit,
	output logic                      out_valid,
	output addsub_pkg::operand_t      out_result,
	output logic                      out_carry,
	output logic                      out_zero,
	input  wire                       out_credit
);

	logic iss_valid;
	addsub_pkg::op_t iss_op;
	addsub_pkg::operand_t iss_a;
	addsub_pkg::operand_t iss_b;
	logic issue_ok;

	logic add_valid;
	addsub_pkg::operand_t add_sum;
	logic add_cout;
	logic sub_valid;
	addsub_pkg::operand_t sub_sum;
	logic sub_cout;

	operand_queue u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_op     (in_op),
		.in_a      (in_a),
		.in_b      (in_b),
		.in_credit (in_credit),
		.issue_ok  (issue_ok),
		.iss_valid (iss_valid),
		.iss_op    (iss_op),
		.iss_a     (iss_a),
		.iss_b     (iss_b)
	);

	// a + b
	ling_adder #(.subtract(1'b0)) u_add (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (iss_valid),
		.a         (iss_a),
		.b         (iss_b),
		.sum_valid (add_valid),
		.sum       (add_sum),
		.cout      (add_cout)
	);

	// a + ~b + 1, also the compare for MAX and MIN
	ling_adder #(.subtract(1'b1)) u_sub (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (iss_valid),
		.a         (iss_a),
		.b         (iss_b),
		.sum_valid (sub_valid),
		.sum       (sub_sum),
		.cout      (sub_cout)
	);

	result_combiner u_comb (
		.clk        (clk),
		.rst_n      (rst_n),
		.iss_valid  (iss_valid),
		.iss_op     (iss_op),
		.iss_a      (iss_a),
		.iss_b      (iss_b),
		.add_valid  (add_valid),
		.add_sum    (add_sum),
		.add_cout   (add_cout),
		.sub_valid  (sub_valid),
		.sub_sum    (sub_sum),
		.sub_cout   (sub_cout),
		.out_credit (out_credit),
		.issue_ok   (issue_ok),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_carry  (out_carry),
		.out_zero   (out_zero)
	);

endmodule

`default_nettype wire

//--- sim/addsub_vectors.svh
// Stimulus table of operation codes, operands, credit-return delays and expected results
`ifndef ADDSUB_VECTORS_SVH
`define ADDSUB_VECTORS_SVH

typedef struct packed {
	addsub_pkg::op_t      op;
	addsub_pkg::operand_t a;
	addsub_pkg::operand_t b;
	logic [7:0]           delay;
	addsub_pkg::operand_t exp_result;
	logic                 exp_carry;
} vector_t;

localparam int num_vectors = 24;

// Each row holds op, a, b, cycles until the downstream credit returns,
// expected result and expected carry
localparam vector_t vectors [num_vectors] = '{
	'{addsub_pkg::OP_ADD, 20'h00000, 20'h00000, 8'd0,  20'h00000, 1'b0},
	'{addsub_pkg::OP_ADD, 20'hFFFFF, 20'h00001, 8'd1,  20'h00000, 1'b1},
	'{addsub_pkg::OP_ADD, 20'hFFFFF, 20'hFFFFF, 8'd0,  20'hFFFFE, 1'b1},
	'{addsub_pkg::OP_ADD, 20'h12345, 20'h54321, 8'd3,  20'h66666, 1'b0},
	'{addsub_pkg::OP_ADD, 20'h80000, 20'h80000, 8'd0,  20'h00000, 1'b1},
	'{addsub_pkg::OP_ADD, 20'h55555, 20'hAAAAA, 8'd40, 20'hFFFFF, 1'b0},
	'{addsub_pkg::OP_ADD, 20'h7FFFF, 20'h00001, 8'd35, 20'h80000, 1'b0},
	'{addsub_pkg::OP_SUB, 20'h00000, 20'h00000, 8'd30, 20'h00000, 1'b1},
	'{addsub_pkg::OP_SUB, 20'h00000, 20'h00001, 8'd2,  20'hFFFFF, 1'b0},
	'{addsub_pkg::OP_SUB, 20'hFFFFF, 20'hFFFFF, 8'd0,  20'h00000, 1'b1},
	'{addsub_pkg::OP_SUB, 20'h80000, 20'h00001, 8'd5,  20'h7FFFF, 1'b1},
	'{addsub_pkg::OP_SUB, 20'h12345, 20'h12346, 8'd0,  20'hFFFFF, 1'b0},
	'{addsub_pkg::OP_SUB, 20'hABCDE, 20'h01234, 8'd25, 20'hAAAAA, 1'b1},
	'{addsub_pkg::OP_MAX, 20'h00000, 20'h00000, 8'd0,  20'h00000, 1'b1},
	'{addsub_pkg::OP_MAX, 20'hFFFFF, 20'h00000, 8'd1,  20'hFFFFF, 1'b1},
	'{addsub_pkg::OP_MAX, 20'h00001, 20'hFFFFF, 8'd0,  20'hFFFFF, 1'b0},
	'{addsub_pkg::OP_MAX, 20'h3C3C3, 20'h3C3C3, 8'd12, 20'h3C3C3, 1'b1},
	'{addsub_pkg::OP_MIN, 20'h00000, 20'hFFFFF, 8'd0,  20'h00000, 1'b0},
	'{addsub_pkg::OP_MIN, 20'hFFFFF, 20'hFFFFE, 8'd45, 20'hFFFFE, 1'b1},
	'{addsub_pkg::OP_MIN, 20'h44444, 20'h44444, 8'd0,  20'h44444, 1'b1},
	'{addsub_pkg::OP_MIN, 20'h00000, 20'h12345, 8'd3,  20'h00000, 1'b0},
	'{addsub_pkg::OP_ADD, 20'h0F0F0, 20'hF0F10, 8'd0,  20'h00000, 1'b1},
	'{addsub_pkg::OP_SUB, 20'h00000, 20'hFFFFF, 8'd8,  20'h00001, 1'b0},
	'{addsub_pkg::OP_ADD, 20'h00001, 20'hFFFFF, 8'd0,  20'h00000, 1'b1}
};

`endif

//--- sim/addsub_unit_tb.sv
// Testbench for the add/subtract/compare unit with credit models, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module addsub_unit_tb;

	`include "addsub_vectors.svh"

	localparam int num_random = 40;
	localparam int wait_limit = 500;
	localparam int drain_limit = 2000;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic in_valid = 1'b0;
	addsub_pkg::op_t in_op = addsub_pkg::OP_ADD;
	addsub_pkg::operand_t in_a = '0;
	addsub_pkg::operand_t in_b = '0;
	logic out_credit = 1'b0;
	logic in_credit;
	logic out_valid;
	addsub_pkg::operand_t out_result;
	logic out_carry;
	logic out_zero;

	int up_credits = addsub_pkg::queue_depth;
	int outstanding = 0;
	int cycle_cnt = 0;
	int sent = 0;
	int received = 0;
	int mismatches = 0;
	int other_errors = 0;
	bit aborted = 1'b0;

	// Expected {carry, zero, result} in send order
	logic [addsub_pkg::data_width+1:0] exp_q [$];
	int delay_q [$];
	int due_q [$];

	addsub_unit UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_carry  (out_carry),
		.out_zero   (out_zero),
		.out_credit (out_credit)
	);

	always #2 clk = ~clk;

	function automatic logic [addsub_pkg::data_width+1:0] expected_result(
		input addsub_pkg::op_t op, input addsub_pkg::operand_t a, input addsub_pkg::operand_t b);
		logic [addsub_pkg::data_width:0] full;
		addsub_pkg::operand_t res;
		logic carry;
		full = {1'b0, a} + {1'b0, b};
		res = '0;
		carry = 1'b0;
		case (op)
			addsub_pkg::OP_ADD: begin
				res = full[addsub_pkg::data_width-1:0];
				carry = full[addsub_pkg::data_width];
			end
			addsub_pkg::OP_SUB: begin
				res = a - b;
				carry = (a >= b);
			end
			addsub_pkg::OP_MAX: begin
				res = (a >= b) ? a : b;
				carry = (a >= b);
			end
			default: begin
				res = (a >= b) ? b : a;
				carry = (a >= b);
			end
		endcase
		return {carry, (res == '0), res};
	endfunction

	// Sends one operation once upstream holds a credit
	task automatic send_op(input addsub_pkg::op_t op, input addsub_pkg::operand_t a,
		input addsub_pkg::operand_t b, input logic [addsub_pkg::data_width+1:0] exp,
		input int delay);
		int waited;
		waited = 0;
		if (aborted) begin
			return;
		end
		@(posedge clk);
		while ((up_credits - int'(in_valid)) <= 0 && waited < wait_limit) begin
			in_valid <= 1'b0;
			@(posedge clk);
			waited++;
		end
		if (waited >= wait_limit) begin
			$display("ERROR: timed out waiting for an upstream credit");
			other_errors++;
			aborted = 1'b1;
			in_valid <= 1'b0;
			return;
		end
		in_valid <= 1'b1;
		in_op <= op;
		in_a <= a;
		in_b <= b;
		exp_q.push_back(exp);
		delay_q.push_back(delay);
		sent++;
	endtask

	task automatic check_result(output int delay);
		logic [addsub_pkg::data_width+1:0] exp;
		delay = 0;
		assert (exp_q.size() != 0) else begin
			$display("ERROR: out_valid arrived with no operation outstanding");
			other_errors++;
		end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			delay = delay_q.pop_front();
			received++;
			assert (out_result === exp[addsub_pkg::data_width-1:0]) else begin
				$display("FAILED out_result: got %h, expected %h", out_result,
					exp[addsub_pkg::data_width-1:0]);
				mismatches++;
			end
			assert (out_carry === exp[addsub_pkg::data_width+1]) else begin
				$display("FAILED out_carry: got %h, expected %h", out_carry,
					exp[addsub_pkg::data_width+1]);
				mismatches++;
			end
			assert (out_zero === exp[addsub_pkg::data_width]) else begin
				$display("FAILED out_zero: got %h, expected %h", out_zero,
					exp[addsub_pkg::data_width]);
				mismatches++;
			end
		end
	endtask

	// Upstream credit model
	always @(posedge clk) begin
		if (!rst_n) begin
			up_credits <= addsub_pkg::queue_depth;
		end else begin
			up_credits <= up_credits - int'(in_valid) + int'(in_credit);
			assert (up_credits >= 0 && up_credits <= addsub_pkg::queue_depth) else begin
				$display("ERROR: upstream credit count out of range (%0d)", up_credits);
				other_errors++;
			end
		end
	end

	// Downstream model that checks each result and returns its credit after the delay
	always @(posedge clk) begin : downstream
		int delay;
		cycle_cnt++;
		out_credit <= 1'b0;
		if (rst_n) begin
			if (out_credit) begin
				outstanding--;
			end
			if (out_valid) begin
				outstanding++;
				check_result(delay);
				due_q.push_back(cycle_cnt + delay);
			end
			assert (outstanding <= addsub_pkg::out_credits) else begin
				$display("ERROR: more results outstanding than downstream credits allow");
				other_errors++;
			end
			if (due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
				out_credit <= 1'b1;
				void'(due_q.pop_front());
			end
		end
	end

	initial begin
		addsub_pkg::op_t r_op;
		addsub_pkg::operand_t r_a;
		addsub_pkg::operand_t r_b;
		int r_delay;
		int waited;
		void'($urandom(32'h869e0abd));
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < num_vectors; i++) begin
			send_op(vectors[i].op, vectors[i].a, vectors[i].b,
				{vectors[i].exp_carry, (vectors[i].exp_result == '0), vectors[i].exp_result},
				int'(vectors[i].delay));
		end
		for (int i = 0; i < num_random; i++) begin
			r_op = addsub_pkg::op_t'($urandom_range(3, 0));
			r_a = addsub_pkg::operand_t'($urandom());
			// Near-equal pairs now and then for the compare
			if (i % 4 == 0) begin
				r_b = r_a ^ addsub_pkg::operand_t'($urandom_range(15, 0));
			end else begin
				r_b = addsub_pkg::operand_t'($urandom());
			end
			// Occasional long credit delay so the queue fills up
			r_delay = (i % 8 == 7) ? int'(30 + $urandom_range(20, 0)) : int'($urandom_range(6, 0));
			send_op(r_op, r_a, r_b, expected_result(r_op, r_a, r_b), r_delay);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		waited = 0;
		while ((received < sent || due_q.size() != 0 || out_credit ||
			up_credits != addsub_pkg::queue_depth) && waited < drain_limit) begin
			@(negedge clk);
			waited++;
		end
		if (waited >= drain_limit) begin
			$display("ERROR: timed out waiting for the pipeline to drain");
			other_errors++;
		end
		// Idle cycles to catch any extra out_valid
		repeat (16) @(negedge clk);
		assert (received == sent) else begin
			$display("ERROR: %0d results received for %0d operations sent", received, sent);
			other_errors++;
		end
		assert (up_credits == addsub_pkg::queue_depth) else begin
			$display("FAILED up_credits: got %h, expected %h", up_credits,
				addsub_pkg::queue_depth);
			mismatches++;
		end
		$display("Summary: %0d sent, %0d received, %0d mismatches, %0d other errors",
			sent, received, mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- addsub_unit.f
+incdir+sim
common/addsub_pkg.sv
ling_adder/ling_prefix_tree.sv
ling_adder/ling_adder.sv
design/operand_queue.sv
design/result_combiner.sv
design/addsub_unit.sv
sim/addsub_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module addsub_unit_tb \
	-f addsub_unit.f \
	-o sim_addsub_unit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_addsub_unit > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

grep -q "Test failures found" "$log_file"
grep_status=$?
if [ $grep_status -eq 0 ]; then
	echo "Simulation reported failures"
	exit 1
fi
if [ $grep_status -ne 1 ]; then
	echo "Could not search $log_file"
	exit 1
fi

echo "Simulation passed"
exit 0
